//--- project.f
src/tcb_pkg.sv
src/tcb_dec.sv
src/tcb_dmx.sv
src/tcb_mem.sv
src/tcb_gpio.sv
src/tcb_sys.sv
bench/tb_tcb_sys.sv

//--- Makefile
# Verilator build and run for the tcb subsystem

TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_tcb_sys
FILELIST = project.f
OBJ_DIR  = obj_dir

BIN  = $(OBJ_DIR)/V$(TOP)
SRCS = $(wildcard src/*.sv) $(wildcard bench/*.sv)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulator is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- bench/tb_tcb_sys.sv
/*
  tcb subsystem testbench
  lfsr driven bus traffic checked against a reference model
*/
`timescale 1ns/1ns
`default_nettype none

module tb_tcb_sys;

  import tcb_pkg::*;

  // planned test length in cycles, limit is twice that
  localparam int unsigned test_len  = 2000;
  localparam int unsigned cyc_limit = 2 * test_len;

  // dut ports
  logic              sub;
  logic              reset;
  logic              vld;
  logic              wen;
  logic [tcb_aw-1:0] adr;
  logic [tcb_bw-1:0] ben;
  logic [tcb_dw-1:0] wdt;
  logic              rdy;
  logic [tcb_dw-1:0] rdt;
  logic              err;
  logic [gpio_w-1:0] gpio_in;
  logic [gpio_w-1:0] gpio_out;

  // reference model state
  logic [tcb_dw-1:0] model_mem [mem_depth];
  logic [gpio_w-1:0] model_out;
  logic [tcb_dw-1:0] exp_rdt;
  logic              exp_err;
  logic [tcb_dw-1:0] merged;

  // stimulus state
  logic [31:0]       lfsr;
  logic [7:0]        words [16];
  int unsigned       cyc = 0;

  tcb_sys i_dut (
    .sub      (sub),
    .reset    (reset),
    .vld      (vld),
    .wen      (wen),
    .adr      (adr),
    .ben      (ben),
    .wdt      (wdt),
    .rdy      (rdy),
    .rdt      (rdt),
    .err      (err),
    .gpio_in  (gpio_in),
    .gpio_out (gpio_out)
  );

  initial sub = 1'b0;
  always #4 sub = ~sub;

  ////////////////////
  // helpers
  ////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped");
  endtask

  // right shifting galois form, taps 32 31 29 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] r;
    r = '0;
    for (int unsigned k = 0; k < n; k++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
    return r;
  endfunction

  // called 1 ns after an edge, returns 1 ns after the accepting edge
  task automatic bus_xfer(input logic w, input logic [tcb_aw-1:0] a,
                          input logic [tcb_bw-1:0] b, input logic [tcb_dw-1:0] d);
    vld = 1'b1;
    wen = w;
    adr = a;
    ben = b;
    wdt = d;
    @(posedge sub);
    // hold the request until ready
    while (!rdy) begin
      @(posedge sub);
    end
    #1;
  endtask

  task automatic bus_idle();
    vld = 1'b0;
    @(posedge sub);
    #1;
  endtask

  ////////////////////
  // reference model
  ////////////////////

  always @(posedge sub) begin
    if (reset) begin
      model_out <= '0;
      exp_rdt   <= '0;
      exp_err   <= 1'b0;
    end else if (vld && rdy) begin
      exp_rdt <= '0;
      exp_err <= 1'b0;
      if (adr[15:10] == 6'd0) begin
        // memory, 1 KiB at 0x0000
        if (wen) begin
          merged = model_mem[adr[9:2]];
          for (int b = 0; b < 4; b++) begin
            if (ben[b]) begin
              merged[8*b +: 8] = wdt[8*b +: 8];
            end
          end
          model_mem[adr[9:2]] <= merged;
        end else begin
          exp_rdt <= model_mem[adr[9:2]];
        end
      end else if (adr[15:4] == 12'h100) begin
        // gpio, 16 bytes at 0x1000
        case (adr[3:2])
          reg_out: begin
            if (wen && ben[0]) begin
              model_out <= wdt[7:0];
            end else if (!wen) begin
              exp_rdt <= {24'd0, model_out};
            end
          end
          // toggle reads as zero
          reg_tgl: begin
            if (wen) begin
              model_out <= model_out ^ wdt[7:0];
            end
          end
          // pins held stable long before any read
          reg_in: begin
            if (wen) begin
              exp_err <= 1'b1;
            end else begin
              exp_rdt <= {24'd0, gpio_in};
            end
          end
          default: exp_err <= 1'b1;
        endcase
      end else begin
        exp_err <= 1'b1;
      end
    end
  end

  ////////////////////
  // checks
  ////////////////////

  // clean state right after reset
  assert property (@(posedge sub) $fell(reset) |-> (rdt == '0) && !err && (gpio_out == '0))
    else abort_run($sformatf("error at %0t ns: outputs not cleared by reset", $time));

  // both subordinates are always ready
  assert property (@(posedge sub) disable iff (reset) vld |-> rdy)
    else abort_run($sformatf("error at %0t ns: rdy low while vld is high", $time));

  // response of the last transfer, held until the next one
  assert property (@(posedge sub) disable iff (reset) (rdt == exp_rdt) && (err == exp_err))
    else abort_run($sformatf("error at %0t ns: rdt %h err %b, expected rdt %h err %b",
                             $time, $sampled(rdt), $sampled(err),
                             $sampled(exp_rdt), $sampled(exp_err)));

  assert property (@(posedge sub) disable iff (reset) gpio_out == model_out)
    else abort_run($sformatf("error at %0t ns: gpio_out %h, expected %h",
                             $time, $sampled(gpio_out), $sampled(model_out)));

  always @(posedge sub) begin
    cyc <= cyc + 1;
    if (cyc >= cyc_limit) begin
      abort_run($sformatf("timeout, test still running after %0d cycles", cyc));
    end
  end

  ////////////////////
  // stimulus
  ////////////////////

  initial begin
    reset   = 1'b1;
    vld     = 1'b0;
    wen     = 1'b0;
    adr     = '0;
    ben     = '0;
    wdt     = '0;
    gpio_in = '0;
    lfsr    = 32'hb7f1_5d6c;
    repeat (16) @(posedge sub);
    #1 reset = 1'b0;
    bus_idle();

    // full word first, then a random byte merge on top
    for (int i = 0; i < 16; i++) begin
      words[i] = 8'(rand_bits(8));
      bus_xfer(1'b1, {6'd0, words[i], 2'd0}, 4'hf, rand_bits(32));
    end
    for (int i = 0; i < 16; i++) begin
      bus_xfer(1'b1, {6'd0, words[i], 2'd0}, 4'(rand_bits(4)), rand_bits(32));
    end
    bus_idle();
    for (int i = 0; i < 16; i++) begin
      bus_xfer(1'b0, {6'd0, words[i], 2'd0}, 4'hf, '0);
    end
    bus_idle();

    // output, toggle, lane 0 only
    bus_xfer(1'b1, 16'h1000, 4'h1, rand_bits(32));
    bus_xfer(1'b1, 16'h1004, 4'hf, rand_bits(32));
    bus_xfer(1'b0, 16'h1000, 4'hf, '0);
    bus_xfer(1'b0, 16'h1004, 4'hf, '0);
    bus_xfer(1'b1, 16'h1000, 4'he, rand_bits(32));
    bus_xfer(1'b0, 16'h1000, 4'hf, '0);
    bus_idle();

    // input pins through the synchronizer
    for (int i = 0; i < 4; i++) begin
      gpio_in = 8'(rand_bits(8));
      repeat (3) bus_idle();
      bus_xfer(1'b0, 16'h1008, 4'hf, '0);
    end
    bus_idle();

    // error cases, state must stay put
    bus_xfer(1'b1, 16'h1008, 4'hf, rand_bits(32));
    bus_xfer(1'b0, 16'h100c, 4'hf, '0);
    bus_xfer(1'b1, 16'h100c, 4'hf, rand_bits(32));
    bus_xfer(1'b0, 16'h2000, 4'hf, '0);
    bus_xfer(1'b1, 16'h0400, 4'hf, rand_bits(32));
    bus_xfer(1'b0, 16'h1010, 4'hf, '0);
    bus_xfer(1'b0, 16'h1000, 4'hf, '0);
    bus_xfer(1'b0, {6'd0, words[0], 2'd0}, 4'hf, '0);
    bus_idle();

    // back to back, alternating subordinates
    for (int i = 0; i < 4; i++) begin
      bus_xfer(1'b0, {6'd0, words[i], 2'd0}, 4'hf, '0);
      bus_xfer(1'b1, 16'h1004, 4'hf, rand_bits(32));
      bus_xfer(1'b1, {6'd0, words[i+4], 2'd0}, 4'(rand_bits(4)), rand_bits(32));
      bus_xfer(1'b0, 16'h1000, 4'hf, '0);
    end
    bus_xfer(1'b0, {6'd0, words[4], 2'd0}, 4'hf, '0);
    repeat (4) bus_idle();

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule : tb_tcb_sys

`default_nettype wire

//--- src/tcb_sys.sv
/*
  tcb subsystem top
  decoder and demultiplexer in front of a word memory and a gpio block
*/
`timescale 1ns/1ns
`default_nettype none

module tcb_sys (
  input  logic                          sub,
  input  logic                          reset,
  // manager request
  input  logic                          vld,
  input  logic                          wen,
  input  tcb_pkg::tcb_adr_u             adr,
  input  logic [tcb_pkg::tcb_bw-1:0]    ben,
  input  logic [tcb_pkg::tcb_dw-1:0]    wdt,
  // manager response
  output logic                          rdy,
  output logic [tcb_pkg::tcb_dw-1:0]    rdt,
  output logic                          err,
  // pins
  input  logic [tcb_pkg::gpio_w-1:0]    gpio_in,
  output logic [tcb_pkg::gpio_w-1:0]    gpio_out
);

  import tcb_pkg::*;

  // decoded port
  logic [tcb_pl-1:0] sel;

  // per port handshake and response
  logic              man_vld [tcb_pn];
  logic              man_wen [tcb_pn];
  logic              man_rdy [tcb_pn];
  logic [tcb_dw-1:0] man_rdt [tcb_pn];
  logic              man_err [tcb_pn];

  // shared payload
  tcb_adr_u          man_adr;
  logic [tcb_bw-1:0] man_ben;
  logic [tcb_dw-1:0] man_wdt;

  ////////////////////
  // input side
  ////////////////////

  tcb_dec i_dec (
    .sub   (sub),
    .reset (reset),
    .adr   (adr),
    .vld   (vld),
    .sel   (sel)
  );

  ////////////////////
  // interconnect
  ////////////////////

  tcb_dmx i_dmx (
    .sub     (sub),
    .reset   (reset),
    .sel     (sel),
    .vld     (vld),
    .wen     (wen),
    .adr     (adr),
    .ben     (ben),
    .wdt     (wdt),
    .rdy     (rdy),
    .rdt     (rdt),
    .err     (err),
    .man_vld (man_vld),
    .man_wen (man_wen),
    .man_adr (man_adr),
    .man_ben (man_ben),
    .man_wdt (man_wdt),
    .man_rdy (man_rdy),
    .man_rdt (man_rdt),
    .man_err (man_err)
  );

  ////////////////////
  // subordinates
  ////////////////////

  tcb_mem i_mem (
    .sub   (sub),
    .reset (reset),
    .vld   (man_vld[port_mem]),
    .wen   (man_wen[port_mem]),
    .adr   (man_adr),
    .ben   (man_ben),
    .wdt   (man_wdt),
    .rdy   (man_rdy[port_mem]),
    .rdt   (man_rdt[port_mem]),
    .err   (man_err[port_mem])
  );

  tcb_gpio i_gpio (
    .sub      (sub),
    .reset    (reset),
    .vld      (man_vld[port_gpio]),
    .wen      (man_wen[port_gpio]),
    .adr      (man_adr),
    .ben      (man_ben),
    .wdt      (man_wdt),
    .rdy      (man_rdy[port_gpio]),
    .rdt      (man_rdt[port_gpio]),
    .err      (man_err[port_gpio]),
    .gpio_in  (gpio_in),
    .gpio_out (gpio_out)
  );

endmodule : tcb_sys

`default_nettype wire

//--- src/tcb_gpio.sv
/*
  tcb gpio register subordinate
  output, toggle and synchronized input registers, errors on bad accesses
*/
`timescale 1ns/1ns
`default_nettype none

module tcb_gpio (
  input  logic                          sub,
  input  logic                          reset,
  input  logic                          vld,
  input  logic                          wen,
  input  tcb_pkg::tcb_adr_u             adr,
  input  logic [tcb_pkg::tcb_bw-1:0]    ben,
  input  logic [tcb_pkg::tcb_dw-1:0]    wdt,
  output logic                          rdy,
  output logic [tcb_pkg::tcb_dw-1:0]    rdt,
  output logic                          err,
  input  logic [tcb_pkg::gpio_w-1:0]    gpio_in,
  output logic [tcb_pkg::gpio_w-1:0]    gpio_out
);

  import tcb_pkg::*;

  // output register
  logic [gpio_w-1:0] out_q;

  // two flop input synchronizer
  logic [gpio_w-1:0] in_meta;
  logic [gpio_w-1:0] in_sync;

  // access decode
  logic              trn;
  logic              hit;
  logic              bad;
  logic              ok_wr;
  logic [tcb_dw-1:0] rd_val;

  assign rdy = 1'b1;
  assign trn = vld && rdy;

  ////////////////////
  // decode
  ////////////////////

  // the decoder also sends unmatched addresses here
  assign hit = ((adr & region_mask[port_gpio]) == region_base[port_gpio]);

  // outside region, index 3, or write to the input register
  assign bad = !hit
            || (adr.gpr.idx == 2'd3)
            || (wen && (adr.gpr.idx == reg_in));

  assign ok_wr = trn && wen && !bad;

  always_comb begin
    rd_val = '0;
    case (adr.gpr.idx)
      reg_out: rd_val[gpio_w-1:0] = out_q;
      reg_in:  rd_val[gpio_w-1:0] = in_sync;
      // toggle reads as zero
      default: rd_val = '0;
    endcase
  end

  ////////////////////
  // registers
  ////////////////////

  always_ff @(posedge sub) begin
    if (reset) begin
      out_q <= '0;
    end else if (ok_wr) begin
      // byte lane 0 only
      if ((adr.gpr.idx == reg_out) && ben[0]) begin
        out_q <= wdt[gpio_w-1:0];
      end else if (adr.gpr.idx == reg_tgl) begin
        out_q <= out_q ^ wdt[gpio_w-1:0];
      end
    end
  end

  always_ff @(posedge sub) begin
    if (reset) begin
      in_meta <= '0;
      in_sync <= '0;
    end else begin
      in_meta <= gpio_in;
      in_sync <= in_meta;
    end
  end

  assign gpio_out = out_q;

  ////////////////////
  // response
  ////////////////////

  // errors and writes return zero data
  always_ff @(posedge sub) begin
    if (reset) begin
      rdt <= '0;
      err <= 1'b0;
    end else if (trn) begin
      rdt <= (wen || bad) ? '0 : rd_val;
      err <= bad;
    end
  end

  ////////////////////
  // checks
  ////////////////////

  property err_after_trn;
    @(posedge sub) disable iff (reset)
    $rose(err) |-> $past(trn);
  endproperty

  assert property (err_after_trn)
    else $error("tcb_gpio: error raised without a transfer");

endmodule : tcb_gpio

`default_nettype wire

//--- src/tcb_mem.sv
/*
  tcb word memory subordinate
  256 words with byte write enables and a registered read port
*/
`timescale 1ns/1ns
`default_nettype none

module tcb_mem (
  input  logic                          sub,
  input  logic                          reset,
  input  logic                          vld,
  input  logic                          wen,
  input  tcb_pkg::tcb_adr_u             adr,
  input  logic [tcb_pkg::tcb_bw-1:0]    ben,
  input  logic [tcb_pkg::tcb_dw-1:0]    wdt,
  output logic                          rdy,
  output logic [tcb_pkg::tcb_dw-1:0]    rdt,
  output logic                          err
);

  import tcb_pkg::*;

  // storage
  logic [tcb_dw-1:0] mem_arr [mem_depth];

  // transfer strobes
  logic trn;
  logic trn_wr;
  logic trn_rd;

  // never stalls, never fails
  assign rdy = 1'b1;
  assign err = 1'b0;

  assign trn    = vld && rdy;
  assign trn_wr = trn && wen;
  assign trn_rd = trn && !wen;

  ////////////////////
  // write port
  ////////////////////

  always_ff @(posedge sub) begin
    if (trn_wr) begin
      for (int unsigned b = 0; b < tcb_bw; b++) begin
        // per byte lane
        if (ben[b]) begin
          mem_arr[adr.mem.idx][8*b +: 8] <= wdt[8*b +: 8];
        end
      end
    end
  end

  ////////////////////
  // read port
  ////////////////////

  // full word regardless of byte enables
  // writes answer with zero
  always_ff @(posedge sub) begin
    if (reset) begin
      rdt <= '0;
    end else if (trn_rd) begin
      rdt <= mem_arr[adr.mem.idx];
    end else if (trn_wr) begin
      rdt <= '0;
    end
  end

  ////////////////////
  // checks
  ////////////////////

  // word aligned accesses only
  property adr_aligned;
    @(posedge sub) disable iff (reset)
    trn |-> (adr.mem.off == 2'b00);
  endproperty

  assert property (adr_aligned)
    else $error("tcb_mem: unaligned access");

endmodule : tcb_mem

`default_nettype wire

//--- src/tcb_dmx.sv
/*
  tcb demultiplexer
  fans the request to one port, muxes ready and the delayed response back
*/
`timescale 1ns/1ns
`default_nettype none

module tcb_dmx (
  input  logic                          sub,
  input  logic                          reset,
  // manager side
  input  logic [tcb_pkg::tcb_pl-1:0]    sel,
  input  logic                          vld,
  input  logic                          wen,
  input  tcb_pkg::tcb_adr_u             adr,
  input  logic [tcb_pkg::tcb_bw-1:0]    ben,
  input  logic [tcb_pkg::tcb_dw-1:0]    wdt,
  output logic                          rdy,
  output logic [tcb_pkg::tcb_dw-1:0]    rdt,
  output logic                          err,
  // subordinate side
  output logic                          man_vld [tcb_pkg::tcb_pn],
  output logic                          man_wen [tcb_pkg::tcb_pn],
  output tcb_pkg::tcb_adr_u             man_adr,
  output logic [tcb_pkg::tcb_bw-1:0]    man_ben,
  output logic [tcb_pkg::tcb_dw-1:0]    man_wdt,
  input  logic                          man_rdy [tcb_pkg::tcb_pn],
  input  logic [tcb_pkg::tcb_dw-1:0]    man_rdt [tcb_pkg::tcb_pn],
  input  logic                          man_err [tcb_pkg::tcb_pn]
);

  import tcb_pkg::*;

  // port of the last accepted request
  logic [tcb_pl-1:0] rsp_sel;

  // valids packed for the onehot check
  logic [tcb_pn-1:0] vld_vec;

  // transfer this cycle
  logic trn;

  ////////////////////
  // request
  ////////////////////

  always_comb begin
    for (int unsigned i = 0; i < tcb_pn; i++) begin
      // only the selected port sees valid
      man_vld[i] = vld && (sel == tcb_pl'(i));
      man_wen[i] = wen;
      vld_vec[i] = man_vld[i];
    end
  end

  // payload shared by all ports
  assign man_adr = adr;
  assign man_ben = ben;
  assign man_wdt = wdt;

  // ready in the request phase
  assign rdy = man_rdy[sel];
  assign trn = vld && rdy;

  ////////////////////
  // response
  ////////////////////

  // follow the request into its response cycle
  always_ff @(posedge sub) begin
    if (reset) begin
      rsp_sel <= port_mem;
    end else if (trn) begin
      rsp_sel <= sel;
    end
  end

  assign rdt = man_rdt[rsp_sel];
  assign err = man_err[rsp_sel];

  ////////////////////
  // checks
  ////////////////////

  property vld_onehot;
    @(posedge sub) disable iff (reset)
    $onehot0(vld_vec);
  endproperty

  // accepted by the selected port, answered from it next cycle
  property rsp_follows;
    @(posedge sub) disable iff (reset)
    trn |-> man_vld[sel] && man_rdy[sel] ##1 (rsp_sel == $past(sel));
  endproperty

  assert property (vld_onehot)
    else $error("tcb_dmx: more than one subordinate valid");
  assert property (rsp_follows)
    else $error("tcb_dmx: response not taken from the accepting port");

endmodule : tcb_dmx

`default_nettype wire

//--- src/tcb_dec.sv
/*
  tcb address decoder
  maps a request address onto a subordinate port number
*/
`timescale 1ns/1ns
`default_nettype none

module tcb_dec (
  input  logic                          sub,
  input  logic                          reset,
  input  tcb_pkg::tcb_adr_u             adr,
  input  logic                          vld,
  output logic [tcb_pkg::tcb_pl-1:0]    sel
);

  import tcb_pkg::*;

  ////////////////////
  // region match
  ////////////////////

  // address as a plain word for masking
  logic [tcb_aw-1:0] adr_w;

  // one bit per region
  logic [tcb_pn-1:0] hit;

  assign adr_w = adr;

  always_comb begin
    for (int unsigned i = 0; i < tcb_pn; i++) begin
      hit[i] = ((adr_w & region_mask[i]) == region_base[i]);
    end
  end

  ////////////////////
  // priority select
  ////////////////////

  // walk from the last port down
  // so the lowest matching port wins
  always_comb begin
    // unmatched addresses land on gpio, which flags an error
    sel = port_gpio;
    for (int i = tcb_pn - 1; i >= 0; i--) begin
      if (hit[i]) begin
        sel = tcb_pl'(i);
      end
    end
  end

  ////////////////////
  // checks
  ////////////////////

  // decoded address must be fully known during a request
  property adr_known;
    @(posedge sub) disable iff (reset)
    vld |-> !$isunknown(adr);
  endproperty

  assert property (adr_known)
    else $error("tcb_dec: unknown address bits while vld is high");

endmodule : tcb_dec

`default_nettype wire

//--- src/tcb_pkg.sv
/*
  tcb subsystem package
  bus widths, port map, region table, register indices and address views
*/
`default_nettype none

package tcb_pkg;

  ////////////////////
  // bus widths
  ////////////////////

  localparam int unsigned tcb_aw = 16;
  localparam int unsigned tcb_dw = 32;
  localparam int unsigned tcb_bw = tcb_dw / 8;

  ////////////////////
  // subordinate ports
  ////////////////////

  localparam int unsigned tcb_pn = 2;
  localparam int unsigned tcb_pl = $clog2(tcb_pn);

  localparam logic [tcb_pl-1:0] port_mem  = 1'd0;
  localparam logic [tcb_pl-1:0] port_gpio = 1'd1;

  // per port base address and mask of compared bits
  // memory 1 KiB at 0x0000, gpio 16 bytes at 0x1000
  localparam logic [tcb_aw-1:0] region_base [tcb_pn] = '{16'h0000, 16'h1000};
  localparam logic [tcb_aw-1:0] region_mask [tcb_pn] = '{16'hfc00, 16'hfff0};

  ////////////////////
  // subordinates
  ////////////////////

  localparam int unsigned mem_depth = 256;
  localparam int unsigned gpio_w    = 8;

  // gpio register indices, index 3 is invalid
  localparam logic [1:0] reg_out = 2'd0;
  localparam logic [1:0] reg_tgl = 2'd1;
  localparam logic [1:0] reg_in  = 2'd2;

  ////////////////////
  // address views
  ////////////////////

  // memory view, word index above byte offset
  typedef struct packed {
    logic [5:0] rgn;
    logic [7:0] idx;
    logic [1:0] off;
  } tcb_adr_mem_t;

  // register view, small index near the bottom
  typedef struct packed {
    logic [5:0] rgn;
    logic [5:0] unu;
    logic [1:0] idx;
    logic [1:0] off;
  } tcb_adr_gpr_t;

  typedef union packed {
    tcb_adr_mem_t mem;
    tcb_adr_gpr_t gpr;
  } tcb_adr_u;

endpackage : tcb_pkg

`default_nettype wire
